// File: hw/vga.sv
// Display controller top; video memory is an external SRAM with registered read data
`timescale 1ns/1ps

module vga (
  input  logic        wb_clk_i,
  input  logic        reset_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  input  logic [15:0] wb_adr_i,
  input  logic        wb_we_i,
  input  logic        wb_tga_i,
  input  logic [1:0]  wb_sel_i,
  input  logic        wb_stb_i,
  input  logic        wb_cyc_i,
  output logic        wb_ack_o,
  output logic [3:0]  vga_red_o,
  output logic [3:0]  vga_green_o,
  output logic [3:0]  vga_blue_o,
  output logic        horiz_sync_o,
  output logic        vert_sync_o,
  output logic [15:0] csrm_adr_o,
  output logic [1:0]  csrm_sel_o,
  output logic        csrm_we_o,
  output logic [15:0] csrm_dat_o,
  input  logic [15:0] csrm_dat_i
);

  // Host to CPU memory interface
  logic        mem_stb;
  logic        mem_we;
  logic [15:0] mem_adr;
  logic [1:0]  mem_sel;
  logic [15:0] mem_wdat;
  logic        mem_ack;
  logic [15:0] mem_rdat;

  // Configuration
  logic [15:0] start_addr;
  logic        graphics;
  logic [1:0]  raster_op;
  logic [3:0]  pal_idx;
  logic [11:0] pal_rgb;

  // Requesters to arbiter
  logic        cpu_valid;
  logic        cpu_ready;
  logic        cpu_we;
  logic [15:0] cpu_adr;
  logic [15:0] cpu_wdat;
  logic        cpu_rvalid;
  logic [15:0] cpu_rdat;
  logic        fetch_stb;
  logic [15:0] fetch_adr;
  logic [15:0] fetch_dat;

  vga_host_port host_port (
    .wb_clk_i, .reset_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_tga_i,
    .wb_adr_i, .wb_sel_i, .wb_dat_i, .wb_ack_o, .wb_dat_o,
    .mem_ack_i (mem_ack), .mem_rdat_i (mem_rdat), .pal_idx_i (pal_idx),
    .mem_stb_o (mem_stb), .mem_we_o (mem_we), .mem_adr_o (mem_adr),
    .mem_sel_o (mem_sel), .mem_wdat_o (mem_wdat),
    .start_addr_o (start_addr), .graphics_o (graphics),
    .raster_op_o (raster_op), .pal_rgb_o (pal_rgb)
  );

  vga_cpu_mem_iface cpu_mem_iface (
    .wb_clk_i, .reset_i,
    .mem_stb_i (mem_stb), .mem_we_i (mem_we), .mem_adr_i (mem_adr),
    .mem_sel_i (mem_sel), .mem_wdat_i (mem_wdat), .raster_op_i (raster_op),
    .cpu_ready_i (cpu_ready), .cpu_rvalid_i (cpu_rvalid), .cpu_rdat_i (cpu_rdat),
    .mem_ack_o (mem_ack), .mem_rdat_o (mem_rdat),
    .cpu_valid_o (cpu_valid), .cpu_we_o (cpu_we), .cpu_adr_o (cpu_adr),
    .cpu_wdat_o (cpu_wdat)
  );

  vga_mem_arbiter mem_arbiter (
    .wb_clk_i, .reset_i,
    .fetch_stb_i (fetch_stb), .fetch_adr_i (fetch_adr),
    .cpu_valid_i (cpu_valid), .cpu_we_i (cpu_we), .cpu_adr_i (cpu_adr),
    .cpu_wdat_i (cpu_wdat), .csrm_dat_i,
    .fetch_dat_o (fetch_dat), .cpu_ready_o (cpu_ready),
    .cpu_rvalid_o (cpu_rvalid), .cpu_rdat_o (cpu_rdat),
    .csrm_adr_o, .csrm_sel_o, .csrm_we_o, .csrm_dat_o
  );

  vga_crtc crtc (
    .wb_clk_i, .reset_i,
    .start_addr_i (start_addr), .graphics_i (graphics),
    .fetch_dat_i (fetch_dat), .pal_rgb_i (pal_rgb),
    .fetch_stb_o (fetch_stb), .fetch_adr_o (fetch_adr), .pal_idx_o (pal_idx),
    .vga_red_o, .vga_green_o, .vga_blue_o, .horiz_sync_o, .vert_sync_o
  );

endmodule

// File: hw/vga_bus_pkg.sv
// Register map and video word layout; addresses are 16-bit word addresses on the host bus
package vga_bus_pkg;

  // Configuration space, selected with the tag high
  localparam logic [15:0] REG_START_ADDR = 16'd0;
  localparam logic [15:0] REG_MODE       = 16'd1;
  localparam logic [15:0] PAL_BASE       = 16'd16;

  // Raster operations, field 2:1 of the mode register
  localparam logic [1:0] ROP_REPLACE = 2'd0;
  localparam logic [1:0] ROP_AND     = 2'd1;
  localparam logic [1:0] ROP_OR      = 2'd2;
  localparam logic [1:0] ROP_XOR     = 2'd3;

  // One video memory word, read as text cell or as four pixels
  typedef union packed {
    struct packed {
      // Attribute byte
      logic [3:0] bg;
      logic [3:0] fg;
      // Character byte, used directly as the dot pattern
      logic [7:0] char_code;
    } text;
    struct packed {
      // Element 0 is the leftmost pixel, in the top nibble
      logic [0:3][3:0] pix;
    } gfx;
  } vram_word_u;

endpackage

// File: hw/vga_cpu_mem_iface.sv
// CPU video memory access; every write is a read-modify-write, one access in flight at a time
`timescale 1ns/1ps

module vga_cpu_mem_iface (
  input  logic        wb_clk_i,
  input  logic        reset_i,
  input  logic        mem_stb_i,
  input  logic        mem_we_i,
  input  logic [15:0] mem_adr_i,
  input  logic [1:0]  mem_sel_i,
  input  logic [15:0] mem_wdat_i,
  input  logic [1:0]  raster_op_i,
  input  logic        cpu_ready_i,
  input  logic        cpu_rvalid_i,
  input  logic [15:0] cpu_rdat_i,
  output logic        mem_ack_o,
  output logic [15:0] mem_rdat_o,
  output logic        cpu_valid_o,
  output logic        cpu_we_o,
  output logic [15:0] cpu_adr_o,
  output logic [15:0] cpu_wdat_o
);

  // One-hot FSM, idle when no flag is set
  logic        rd_req;
  logic        rd_wait;
  logic        wr_req;
  logic        idle;
  logic        ack_q;
  logic [15:0] rdat_q;
  logic [15:0] wdat_q;
  logic [15:0] rop_word;
  logic [15:0] merged;

  assign idle = ~(rd_req | rd_wait | wr_req);

  always_comb begin
    case (raster_op_i)
      vga_bus_pkg::ROP_AND: rop_word = cpu_rdat_i & mem_wdat_i;
      vga_bus_pkg::ROP_OR:  rop_word = cpu_rdat_i | mem_wdat_i;
      vga_bus_pkg::ROP_XOR: rop_word = cpu_rdat_i ^ mem_wdat_i;
      default:              rop_word = mem_wdat_i;
    endcase
  end

  // Unselected bytes keep the old word
  assign merged = {mem_sel_i[1] ? rop_word[15:8] : cpu_rdat_i[15:8],
                   mem_sel_i[0] ? rop_word[7:0] : cpu_rdat_i[7:0]};

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      rd_req  <= 1'b0;
      rd_wait <= 1'b0;
      wr_req  <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      // stb is still high in the cycle after ack, so skip it
      if (idle && mem_stb_i && !ack_q) begin
        rd_req <= 1'b1;
      end
      if (rd_req && cpu_ready_i) begin
        rd_req  <= 1'b0;
        rd_wait <= 1'b1;
      end
      if (rd_wait && cpu_rvalid_i) begin
        rd_wait <= 1'b0;
        if (mem_we_i) wr_req <= 1'b1;
        else ack_q <= 1'b1;
      end
      if (wr_req && cpu_ready_i) begin
        wr_req <= 1'b0;
        ack_q  <= 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rd_wait && cpu_rvalid_i) begin
      rdat_q <= cpu_rdat_i;
      wdat_q <= merged;
    end
  end

  // Address comes from the host, which holds it until ack
  assign cpu_valid_o = rd_req | wr_req;
  assign cpu_we_o    = wr_req;
  assign cpu_adr_o   = mem_adr_i;
  assign cpu_wdat_o  = wdat_q;
  assign mem_ack_o   = ack_q;
  assign mem_rdat_o  = rdat_q;

endmodule

// File: hw/vga_crtc.sv
// CRT controller with fixed timing; a mode change takes effect mid-line without resync
`timescale 1ns/1ps

module vga_crtc (
  input  logic        wb_clk_i,
  input  logic        reset_i,
  input  logic [15:0] start_addr_i,
  input  logic        graphics_i,
  input  logic [15:0] fetch_dat_i,
  input  logic [11:0] pal_rgb_i,
  output logic        fetch_stb_o,
  output logic [15:0] fetch_adr_o,
  output logic [3:0]  pal_idx_o,
  output logic [3:0]  vga_red_o,
  output logic [3:0]  vga_green_o,
  output logic [3:0]  vga_blue_o,
  output logic        horiz_sync_o,
  output logic        vert_sync_o
);

  logic [$clog2(vga_timing_pkg::H_TOTAL)-1:0] h_cnt;
  logic [$clog2(vga_timing_pkg::V_TOTAL)-1:0] v_cnt;
  logic        dot_vis;
  logic        hs_now;
  logic        vs_now;
  logic        word_edge;
  logic [15:0] line_base;
  logic [15:0] word_idx;
  logic [vga_timing_pkg::PIX_LAT-2:0] vis_d;
  logic [vga_timing_pkg::PIX_LAT-2:0] hs_d;
  logic [vga_timing_pkg::PIX_LAT-2:0] vs_d;
  logic [2:0]  x_d [vga_timing_pkg::PIX_LAT-1];
  logic [2:0]  dot_x;
  logic [1:0]  fetch_d;
  vga_bus_pkg::vram_word_u word_q;

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (int'(h_cnt) == vga_timing_pkg::H_TOTAL - 1) begin
      h_cnt <= '0;
      if (int'(v_cnt) == vga_timing_pkg::V_TOTAL - 1) v_cnt <= '0;
      else v_cnt <= v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign dot_vis = (int'(v_cnt) < vga_timing_pkg::V_VISIBLE) &&
                   (int'(h_cnt) < vga_timing_pkg::H_VISIBLE);
  assign hs_now  = (int'(h_cnt) >= vga_timing_pkg::H_SYNC_START) &&
                   (int'(h_cnt) < vga_timing_pkg::H_SYNC_END);
  assign vs_now  = (int'(v_cnt) >= vga_timing_pkg::V_SYNC_START) &&
                   (int'(v_cnt) < vga_timing_pkg::V_SYNC_END);

  // Text words span 8 dots, graphics words 4
  always_comb begin
    if (graphics_i) begin
      line_base = 16'(int'(v_cnt) * vga_timing_pkg::GFX_WORDS_PER_LINE);
      word_idx  = 16'(h_cnt >> 2);
      word_edge = (h_cnt[1:0] == 2'd0);
    end else begin
      line_base = 16'(int'(v_cnt) * vga_timing_pkg::TEXT_WORDS_PER_LINE);
      word_idx  = 16'(h_cnt >> 3);
      word_edge = (h_cnt[2:0] == 3'd0);
    end
  end

  // Fetch at the word's first dot slot, ahead of its pixels by the pipeline
  assign fetch_stb_o = dot_vis & word_edge;
  assign fetch_adr_o = start_addr_i + line_base + word_idx;

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      vis_d   <= '0;
      hs_d    <= '0;
      vs_d    <= '0;
      fetch_d <= '0;
    end else begin
      vis_d   <= {vis_d[vga_timing_pkg::PIX_LAT-3:0], dot_vis};
      hs_d    <= {hs_d[vga_timing_pkg::PIX_LAT-3:0], hs_now};
      vs_d    <= {vs_d[vga_timing_pkg::PIX_LAT-3:0], vs_now};
      fetch_d <= {fetch_d[0], fetch_stb_o};
    end
  end

  always_ff @(posedge wb_clk_i) begin
    x_d[0] <= h_cnt[2:0];
    for (int i = 1; i < vga_timing_pkg::PIX_LAT - 1; i++) begin
      x_d[i] <= x_d[i-1];
    end
    // Word is held for all its dots, ready when its first dot decodes
    if (fetch_d[1]) begin
      word_q <= fetch_dat_i;
    end
  end

  assign dot_x = x_d[vga_timing_pkg::PIX_LAT-2];

  always_comb begin
    if (graphics_i) pal_idx_o = word_q.gfx.pix[dot_x[1:0]];
    else if (word_q.text.char_code[3'd7 - dot_x]) pal_idx_o = word_q.text.fg;
    else pal_idx_o = word_q.text.bg;
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      {vga_red_o, vga_green_o, vga_blue_o} <= 12'h0;
      horiz_sync_o <= 1'b1;
      vert_sync_o  <= 1'b1;
    end else begin
      {vga_red_o, vga_green_o, vga_blue_o} <=
        vis_d[vga_timing_pkg::PIX_LAT-2] ? pal_rgb_i : 12'h0;
      horiz_sync_o <= ~hs_d[vga_timing_pkg::PIX_LAT-2];
      // Vertical sync active low in text, active high in graphics
      vert_sync_o  <= graphics_i ? vs_d[vga_timing_pkg::PIX_LAT-2]
                                 : ~vs_d[vga_timing_pkg::PIX_LAT-2];
    end
  end

endmodule

// File: hw/vga_host_port.sv
// Host slave front end; the master must hold the cycle stable until ack and drop stb right after
`timescale 1ns/1ps

module vga_host_port (
  input  logic        wb_clk_i,
  input  logic        reset_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic        wb_tga_i,
  input  logic [15:0] wb_adr_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [15:0] wb_dat_i,
  input  logic        mem_ack_i,
  input  logic [15:0] mem_rdat_i,
  input  logic [3:0]  pal_idx_i,
  output logic        wb_ack_o,
  output logic [15:0] wb_dat_o,
  output logic        mem_stb_o,
  output logic        mem_we_o,
  output logic [15:0] mem_adr_o,
  output logic [1:0]  mem_sel_o,
  output logic [15:0] mem_wdat_o,
  output logic [15:0] start_addr_o,
  output logic        graphics_o,
  output logic [1:0]  raster_op_o,
  output logic [11:0] pal_rgb_o
);

  logic        bus_stb;
  logic        cfg_stb;
  logic        cfg_wr;
  logic        cfg_ack;
  logic [15:0] cfg_rdat;
  logic [2:0]  mode;
  logic        start_hit;
  logic        mode_hit;
  logic        pal_hit;
  logic [11:0] pal [16];

  assign bus_stb   = wb_cyc_i & wb_stb_i;
  assign cfg_stb   = bus_stb & wb_tga_i;
  assign cfg_wr    = cfg_stb & ~cfg_ack & wb_we_i;
  assign start_hit = (wb_adr_i == vga_bus_pkg::REG_START_ADDR);
  assign mode_hit  = (wb_adr_i == vga_bus_pkg::REG_MODE);
  assign pal_hit   = ((wb_adr_i & 16'hfff0) == vga_bus_pkg::PAL_BASE);

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      cfg_ack      <= 1'b0;
      start_addr_o <= '0;
      mode         <= '0;
      for (int i = 0; i < 16; i++) begin
        pal[i] <= '0;
      end
    end else begin
      // Single pulse even while the master still holds stb
      cfg_ack <= cfg_stb & ~cfg_ack;
      if (cfg_wr && start_hit) begin
        if (wb_sel_i[0]) start_addr_o[7:0] <= wb_dat_i[7:0];
        if (wb_sel_i[1]) start_addr_o[15:8] <= wb_dat_i[15:8];
      end
      if (cfg_wr && mode_hit && wb_sel_i[0]) begin
        mode <= wb_dat_i[2:0];
      end
      if (cfg_wr && pal_hit) begin
        if (wb_sel_i[0]) pal[wb_adr_i[3:0]][7:0] <= wb_dat_i[7:0];
        if (wb_sel_i[1]) pal[wb_adr_i[3:0]][11:8] <= wb_dat_i[11:8];
      end
    end
  end

  // Read data lands in the ack cycle; unmapped addresses read zero
  always_ff @(posedge wb_clk_i) begin
    if (start_hit) cfg_rdat <= start_addr_o;
    else if (mode_hit) cfg_rdat <= {13'h0, mode};
    else if (pal_hit) cfg_rdat <= {4'h0, pal[wb_adr_i[3:0]]};
    else cfg_rdat <= '0;
  end

  assign graphics_o  = mode[0];
  assign raster_op_o = mode[2:1];
  // Display side palette port
  assign pal_rgb_o   = pal[pal_idx_i];

  // Memory space passes straight to the CPU memory interface
  assign mem_stb_o  = bus_stb & ~wb_tga_i;
  assign mem_we_o   = wb_we_i;
  assign mem_adr_o  = wb_adr_i;
  assign mem_sel_o  = wb_sel_i;
  assign mem_wdat_o = wb_dat_i;

  assign wb_ack_o = wb_tga_i ? cfg_ack : mem_ack_i;
  assign wb_dat_o = wb_tga_i ? cfg_rdat : mem_rdat_i;

endmodule

// File: hw/vga_mem_arbiter.sv
// SRAM arbiter; display fetches always win and the SRAM must return read data one cycle late
`timescale 1ns/1ps

module vga_mem_arbiter (
  input  logic        wb_clk_i,
  input  logic        reset_i,
  input  logic        fetch_stb_i,
  input  logic [15:0] fetch_adr_i,
  input  logic        cpu_valid_i,
  input  logic        cpu_we_i,
  input  logic [15:0] cpu_adr_i,
  input  logic [15:0] cpu_wdat_i,
  input  logic [15:0] csrm_dat_i,
  output logic [15:0] fetch_dat_o,
  output logic        cpu_ready_o,
  output logic        cpu_rvalid_o,
  output logic [15:0] cpu_rdat_o,
  output logic [15:0] csrm_adr_o,
  output logic [1:0]  csrm_sel_o,
  output logic        csrm_we_o,
  output logic [15:0] csrm_dat_o
);

  logic       cpu_go;
  // Bit 0 owns the address on the pins, bit 1 owns the returning word
  logic [1:0] fetch_tag;
  logic [1:0] cpu_rd_tag;

  assign cpu_ready_o = ~fetch_stb_i;
  assign cpu_go      = cpu_valid_i & ~fetch_stb_i;

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      csrm_we_o  <= 1'b0;
      csrm_sel_o <= 2'b00;
      fetch_tag  <= 2'b00;
      cpu_rd_tag <= 2'b00;
    end else begin
      csrm_we_o  <= cpu_go & cpu_we_i;
      // Byte merging is done upstream, so any access uses the whole word
      csrm_sel_o <= (fetch_stb_i | cpu_go) ? 2'b11 : 2'b00;
      fetch_tag  <= {fetch_tag[0], fetch_stb_i};
      cpu_rd_tag <= {cpu_rd_tag[0], cpu_go & ~cpu_we_i};
    end
  end

  always_ff @(posedge wb_clk_i) begin
    csrm_adr_o <= fetch_stb_i ? fetch_adr_i : cpu_adr_i;
    csrm_dat_o <= cpu_wdat_i;
  end

  assign fetch_dat_o  = fetch_tag[1] ? csrm_dat_i : 16'h0;
  assign cpu_rvalid_o = cpu_rd_tag[1];
  assign cpu_rdat_o   = csrm_dat_i;

endmodule

// File: hw/vga_timing_pkg.sv
// Fixed display geometry sized for simulation; changing it needs the word fetch rules rechecked
package vga_timing_pkg;

  // Horizontal geometry, in dots
  localparam int H_VISIBLE    = 32;
  localparam int H_SYNC_START = 34;
  localparam int H_SYNC_END   = 38;
  localparam int H_TOTAL      = 40;

  // Vertical geometry, in lines
  localparam int V_VISIBLE    = 8;
  localparam int V_SYNC_START = 9;
  localparam int V_SYNC_END   = 11;
  localparam int V_TOTAL      = 12;

  // Text words hold 8 dots, graphics words hold 4
  localparam int TEXT_WORDS_PER_LINE = 4;
  localparam int GFX_WORDS_PER_LINE  = 8;

  // Counter slot to pins: 2 cycles SRAM fetch, 1 word latch, 1 output register
  localparam int PIX_LAT = 4;

endpackage

// File: list.f
hw/vga_timing_pkg.sv
hw/vga_bus_pkg.sv
hw/vga_host_port.sv
hw/vga_cpu_mem_iface.sv
hw/vga_mem_arbiter.sv
hw/vga_crtc.sv
hw/vga.sv
verif/vga_asserts.sv
verif/vga_tb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator, then checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module vga_tb -f list.f \
  --Mdir obj_dir -o vga_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/vga_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "RESULT: PASS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: verif/vga_asserts.sv
// Bus and reset properties for the display controller top; reports only through failed assertions
`timescale 1ns/1ps

module vga_asserts (
  input logic wb_clk_i,
  input logic reset_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic csrm_we_o
);

  // Ack only answers a live cycle
  ack_needs_stb: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    wb_ack_o |-> (wb_stb_i && wb_cyc_i))
    else $error("wb_ack_o high without wb_stb_i and wb_cyc_i");

  // Ack is a single cycle pulse
  ack_single: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("wb_ack_o high two cycles in a row");

  // No SRAM writes while held in reset
  no_write_in_reset: assert property (@(posedge wb_clk_i)
    (reset_i && $past(reset_i)) |-> !csrm_we_o)
    else $error("csrm_we_o high during reset");

endmodule

// File: verif/vga_tb.sv
// Directed testbench with a registered-read SRAM model; assumes the timing package geometry
`timescale 1ns/1ps

module vga_tb;

  localparam int FRAMES = 20;
  localparam longint WATCHDOG_NS =
    longint'(FRAMES) * vga_timing_pkg::H_TOTAL * vga_timing_pkg::V_TOTAL * 20 + 50000;

  logic        wb_clk_i;
  logic        reset_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic        wb_tga_i;
  logic [15:0] wb_adr_i;
  logic [1:0]  wb_sel_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;
  logic [3:0]  vga_red_o;
  logic [3:0]  vga_green_o;
  logic [3:0]  vga_blue_o;
  logic        horiz_sync_o;
  logic        vert_sync_o;
  logic [15:0] csrm_adr_o;
  logic [1:0]  csrm_sel_o;
  logic        csrm_we_o;
  logic [15:0] csrm_dat_o;
  logic [15:0] csrm_dat_i;

  logic [15:0] sram [65536];
  logic [11:0] pal_ref [16];
  logic [15:0] start_ref;
  logic [2:0]  mode_ref;
  int          seed;
  int          err_cnt;
  int          chk_cnt;
  int          test_cnt;

  vga DUT (.*);

  bind vga vga_asserts asserts (.wb_clk_i, .reset_i, .wb_cyc_i, .wb_stb_i, .wb_ack_o,
                                .csrm_we_o);

  initial wb_clk_i = 1'b0;
  always #10 wb_clk_i = ~wb_clk_i;

  // SRAM model with byte enables and data one cycle after the address
  always @(posedge wb_clk_i) begin
    if (csrm_we_o) begin
      if (csrm_sel_o[0]) sram[csrm_adr_o][7:0] <= csrm_dat_o[7:0];
      if (csrm_sel_o[1]) sram[csrm_adr_o][15:8] <= csrm_dat_o[15:8];
    end
    csrm_dat_i <= #1 sram[csrm_adr_o];
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the tests did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic logic [15:0] rand16();
    int r;
    r = $random(seed);
    return r[15:0];
  endfunction

  function automatic logic [15:0] expect_rop(logic [1:0] op, logic [15:0] old_w,
                                             logic [15:0] new_w, logic [1:0] sel);
    logic [15:0] c;
    case (op)
      vga_bus_pkg::ROP_AND: c = old_w & new_w;
      vga_bus_pkg::ROP_OR:  c = old_w | new_w;
      vga_bus_pkg::ROP_XOR: c = old_w ^ new_w;
      default:              c = new_w;
    endcase
    return {sel[1] ? c[15:8] : old_w[15:8], sel[0] ? c[7:0] : old_w[7:0]};
  endfunction

  task automatic compare(input string name, input logic [15:0] exp_v, input logic [15:0] act_v);
    chk_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
    end
  endtask

  // One bus cycle; cycles counts falling edges until ack is seen
  task automatic wb_access(input logic tga, input logic we, input logic [15:0] adr,
                           input logic [1:0] sel, input logic [15:0] dat,
                           output logic [15:0] rdat, output int cycles);
    @(posedge wb_clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_tga_i = tga;
    wb_adr_i = adr;
    wb_sel_i = sel;
    wb_dat_i = dat;
    cycles = 0;
    rdat = '0;
    while (cycles < 200) begin
      @(negedge wb_clk_i);
      cycles++;
      if (wb_ack_o) break;
    end
    if (!wb_ack_o) begin
      err_cnt++;
      $display("No ack within 200 cycles for address %h at %0t", adr, $time);
    end
    rdat = wb_dat_o;
    @(posedge wb_clk_i);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic tga, input logic [15:0] adr, input logic [1:0] sel,
                          input logic [15:0] dat, output int cycles);
    logic [15:0] unused;
    wb_access(tga, 1'b1, adr, sel, dat, unused, cycles);
  endtask

  task automatic wb_read(input logic tga, input logic [15:0] adr, output logic [15:0] rdat,
                         output int cycles);
    wb_access(tga, 1'b0, adr, 2'b11, 16'h0, rdat, cycles);
  endtask

  task automatic set_mode(input logic gfx, input logic [1:0] rop);
    int cyc;
    wb_write(1'b1, vga_bus_pkg::REG_MODE, 2'b01, {13'h0, rop, gfx}, cyc);
    mode_ref = {rop, gfx};
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("%s finished, errors so far %0d", name, err_cnt);
  endtask

  task automatic regs_readback();
    logic [15:0] rd;
    logic [15:0] v;
    int cyc;
    wb_write(1'b1, vga_bus_pkg::REG_START_ADDR, 2'b11, 16'h1234, cyc);
    compare("write ack latency", 16'd2, 16'(cyc));
    wb_write(1'b1, vga_bus_pkg::REG_START_ADDR, 2'b10, 16'habcd, cyc);
    wb_read(1'b1, vga_bus_pkg::REG_START_ADDR, rd, cyc);
    compare("start_addr", 16'hab34, rd);
    compare("read ack latency", 16'd2, 16'(cyc));
    wb_write(1'b1, vga_bus_pkg::REG_MODE, 2'b01, 16'h0007, cyc);
    // Mode lives in the low byte only
    wb_write(1'b1, vga_bus_pkg::REG_MODE, 2'b10, 16'h0000, cyc);
    wb_read(1'b1, vga_bus_pkg::REG_MODE, rd, cyc);
    compare("mode", 16'h0007, rd);
    set_mode(1'b0, vga_bus_pkg::ROP_REPLACE);
    for (int i = 0; i < 16; i++) begin
      v = rand16();
      wb_write(1'b1, vga_bus_pkg::PAL_BASE + 16'(i), 2'b11, v, cyc);
      pal_ref[i] = v[11:0];
      wb_read(1'b1, vga_bus_pkg::PAL_BASE + 16'(i), rd, cyc);
      compare("palette", {4'h0, pal_ref[i]}, rd);
    end
    wb_write(1'b1, vga_bus_pkg::PAL_BASE + 16'd5, 2'b01, 16'hffff, cyc);
    pal_ref[5][7:0] = 8'hff;
    wb_write(1'b1, vga_bus_pkg::PAL_BASE + 16'd6, 2'b10, 16'hffff, cyc);
    pal_ref[6][11:8] = 4'hf;
    wb_read(1'b1, vga_bus_pkg::PAL_BASE + 16'd5, rd, cyc);
    compare("palette low byte", {4'h0, pal_ref[5]}, rd);
    wb_read(1'b1, vga_bus_pkg::PAL_BASE + 16'd6, rd, cyc);
    compare("palette high byte", {4'h0, pal_ref[6]}, rd);
    start_ref = 16'hab34;
    finish_test("regs_readback");
  endtask

  task automatic raster_op_writes();
    logic [15:0] a;
    logic [15:0] old_w;
    logic [15:0] new_w;
    logic [15:0] exp_w;
    logic [15:0] rd;
    logic [1:0]  sel;
    int cyc;
    for (int k = 0; k < 8; k++) begin
      a = 16'h4000 + 16'(k);
      sel = (k < 4) ? 2'b11 : (k[0] ? 2'b01 : 2'b10);
      set_mode(1'b0, k[1:0]);
      old_w = sram[a];
      new_w = rand16();
      exp_w = expect_rop(k[1:0], old_w, new_w, sel);
      wb_write(1'b0, a, sel, new_w, cyc);
      compare("sram word", exp_w, sram[a]);
      wb_read(1'b0, a, rd, cyc);
      compare("memory read", exp_w, rd);
    end
    set_mode(1'b0, vga_bus_pkg::ROP_REPLACE);
    finish_test("raster_op_writes");
  endtask

  function automatic logic sync_pin(input logic vert);
    return vert ? vert_sync_o : horiz_sync_o;
  endfunction

  // Width and spacing of one pulse in clock cycles
  task automatic measure_pulse(input logic vert, input logic act, output int width,
                               output int period);
    logic prev;
    logic cur;
    logic in_pulse;
    prev = sync_pin(vert);
    forever begin
      @(negedge wb_clk_i);
      cur = sync_pin(vert);
      if (prev != act && cur == act) break;
      prev = cur;
    end
    width = 1;
    period = 1;
    in_pulse = 1'b1;
    forever begin
      @(negedge wb_clk_i);
      cur = sync_pin(vert);
      if (in_pulse && cur == act) width++;
      else if (cur == act) break;
      else in_pulse = 1'b0;
      period++;
    end
  endtask

  task automatic sync_timing();
    int w;
    int p;
    for (int g = 0; g < 2; g++) begin
      set_mode(g[0], vga_bus_pkg::ROP_REPLACE);
      measure_pulse(1'b0, 1'b0, w, p);
      compare("hsync width", 16'(vga_timing_pkg::H_SYNC_END - vga_timing_pkg::H_SYNC_START),
              16'(w));
      compare("hsync period", 16'(vga_timing_pkg::H_TOTAL), 16'(p));
      measure_pulse(1'b1, g[0], w, p);
      compare("vsync width", 16'(2 * vga_timing_pkg::H_TOTAL), 16'(w));
      compare("vsync period",
              16'(vga_timing_pkg::V_TOTAL * vga_timing_pkg::H_TOTAL), 16'(p));
    end
    finish_test("sync_timing");
  endtask

  task automatic wait_hsync_fall();
    logic prev;
    prev = horiz_sync_o;
    forever begin
      @(negedge wb_clk_i);
      if (prev && !horiz_sync_o) break;
      prev = horiz_sync_o;
    end
  endtask

  // Checks the visible lines of the next frame against the model SRAM
  task automatic check_frame();
    logic gfx;
    logic act;
    logic prev;
    int   wpl;
    int   dpw;
    int   a;
    logic [3:0]  idx;
    logic [11:0] exp_rgb;
    vga_bus_pkg::vram_word_u u;
    gfx = mode_ref[0];
    act = gfx;
    wpl = gfx ? vga_timing_pkg::GFX_WORDS_PER_LINE : vga_timing_pkg::TEXT_WORDS_PER_LINE;
    dpw = gfx ? 4 : 8;
    prev = vert_sync_o;
    forever begin
      @(negedge wb_clk_i);
      if (prev == act && vert_sync_o != act) break;
      prev = vert_sync_o;
    end
    for (int y = 0; y < vga_timing_pkg::V_VISIBLE; y++) begin
      wait_hsync_fall();
      // Next line's dot 0 sits H_TOTAL - H_SYNC_START cycles after the fall
      repeat (vga_timing_pkg::H_TOTAL - vga_timing_pkg::H_SYNC_START - 1) @(negedge wb_clk_i);
      for (int x = 0; x < vga_timing_pkg::H_SYNC_START; x++) begin
        @(negedge wb_clk_i);
        exp_rgb = 12'h0;
        if (x < vga_timing_pkg::H_VISIBLE) begin
          a = int'(start_ref) + y * wpl + x / dpw;
          u = sram[a[15:0]];
          if (gfx) idx = u.gfx.pix[x % 4];
          else idx = u.text.char_code[7 - x % 8] ? u.text.fg : u.text.bg;
          exp_rgb = pal_ref[idx];
        end
        compare("rgb", {4'h0, exp_rgb}, {4'h0, vga_red_o, vga_green_o, vga_blue_o});
      end
    end
  endtask

  task automatic set_start(input logic [15:0] s);
    int cyc;
    wb_write(1'b1, vga_bus_pkg::REG_START_ADDR, 2'b11, s, cyc);
    start_ref = s;
  endtask

  task automatic text_display();
    for (int i = 0; i < 32; i++) begin
      sram[i] = rand16();
    end
    set_start(16'h0000);
    set_mode(1'b0, vga_bus_pkg::ROP_REPLACE);
    check_frame();
    finish_test("text_display");
  endtask

  task automatic graphics_display();
    for (int i = 0; i < 64; i++) begin
      sram[16'h2345 + i] = rand16();
    end
    set_start(16'h2345);
    set_mode(1'b1, vga_bus_pkg::ROP_REPLACE);
    check_frame();
    finish_test("graphics_display");
  endtask

  task automatic traffic_during_display();
    logic [15:0] d;
    logic [15:0] rd;
    int cyc;
    fork
      check_frame();
      for (int i = 0; i < 40; i++) begin
        d = rand16();
        wb_write(1'b0, 16'h8000 + 16'(i), 2'b11, d, cyc);
        compare("sram word under display", d, sram[16'h8000 + i]);
        wb_read(1'b0, 16'h8000 + 16'(i), rd, cyc);
        compare("memory read under display", d, rd);
      end
    join
    finish_test("traffic_during_display");
  endtask

  initial begin
    seed     = 32'h95c2;
    err_cnt  = 0;
    chk_cnt  = 0;
    test_cnt = 0;
    reset_i  = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_tga_i = 1'b0;
    wb_adr_i = '0;
    wb_sel_i = '0;
    wb_dat_i = '0;
    csrm_dat_i = '0;
    start_ref = '0;
    mode_ref  = '0;
    for (int i = 0; i < 16; i++) pal_ref[i] = '0;
    // Fill depends on every address bit
    for (int i = 0; i < 65536; i++) begin
      sram[i] = 16'(i) ^ {16'(i) << 5} ^ 16'h3c96;
    end
    repeat (4) @(posedge wb_clk_i);
    #1;
    reset_i = 1'b0;
    regs_readback();
    raster_op_writes();
    sync_timing();
    text_display();
    graphics_display();
    traffic_during_display();
    $display("Tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
